// ==== common/sd_pkg.sv ====
package sd_pkg;

  // system clock and spi clock rates
  localparam int sys_clk_hz = 100_000_000;
  // 400 kHz during init
  localparam int slow_half_div = sys_clk_hz / (2 * 400_000);
  // 25 MHz once the card is ready
  localparam int fast_half_div = sys_clk_hz / (2 * 25_000_000);
  // divider counter width, sized for the slow rate
  localparam int div_w = $clog2(slow_half_div);

  // power-up clocking with cs high
  localparam int powerup_sclk = 80;
  localparam int powerup_cycles = powerup_sclk * 2 * slow_half_div;
  localparam int pwr_cnt_w = $clog2(powerup_cycles);

  // sclk rising edges of idle miso before giving up on a response
  localparam int resp_timeout_sclk = 100;
  // attempts for cmd0, and for the acmd41 round
  localparam int retry_limit = 10;

  // frame and response lengths in bits
  localparam int cmd_bits = 48;
  localparam int r1_bits = 8;
  localparam int r7_bits = 40;

  // command indices
  localparam logic [5:0] cmd0 = 6'd0;
  localparam logic [5:0] cmd8 = 6'd8;
  localparam logic [5:0] cmd55 = 6'd55;
  localparam logic [5:0] acmd41 = 6'd41;
  localparam logic [5:0] cmd58 = 6'd58;

  // vhs = 2.7-3.6 V, check pattern 0xaa
  localparam logic [31:0] cmd8_arg = 32'h0000_01aa;
  // hcs, host supports high capacity
  localparam logic [31:0] acmd41_arg = 32'h4000_0000;

  // response log fifo
  localparam int log_depth = 4;
  localparam int log_ptr_w = $clog2(log_depth);

  // one finished command, as traced on the log stream
  typedef struct packed {
    logic [5:0] cmd_index;
    logic [7:0] r1;
    logic       timed_out;
  } resp_rec_t;

  // command handed from sequencer to shifter
  typedef struct packed {
    logic [5:0]  index;
    logic [31:0] argument;
    // 8 or 40
    logic [5:0]  resp_len;
  } sd_cmd_req_t;

  // sequencer states, the command in flight is kept separately
  typedef enum logic [2:0] {
    st_powerup,
    st_issue,
    st_wait,
    st_push,
    st_done,
    st_error
  } init_state_t;

endpackage

// ==== logic/resp_log_fifo.sv ====
`timescale 1ns/10ps

module resp_log_fifo (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  sd_pkg::resp_rec_t in_rec,
  input  logic              out_ready,
  output logic              in_ready,
  output logic              out_valid,
  output sd_pkg::resp_rec_t out_rec
);

  sd_pkg::resp_rec_t mem [sd_pkg::log_depth];
  // depth is a power of two, pointers wrap on their own
  logic [sd_pkg::log_ptr_w-1:0] wr_ptr;
  logic [sd_pkg::log_ptr_w-1:0] rd_ptr;
  logic [sd_pkg::log_ptr_w:0] count;
  logic do_push;
  logic do_pop;

  assign in_ready = (count != (sd_pkg::log_ptr_w + 1)'(sd_pkg::log_depth));
  assign out_valid = (count != '0);
  assign out_rec = mem[rd_ptr];
  assign do_push = in_valid && in_ready;
  assign do_pop = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_rec;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the level alone
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== sd_init/sd_clock_gen.sv ====
`timescale 1ns/10ps

module sd_clock_gen (
  input  logic clk,
  input  logic reset,
  input  logic run,
  input  logic fast_sel,
  output logic sd_sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [sd_pkg::div_w-1:0] cnt;
  logic [sd_pkg::div_w-1:0] half_div;
  // rate in use, only follows fast_sel at a toggle
  logic fast_q;
  logic toggle;

  assign half_div = fast_q ? sd_pkg::div_w'(sd_pkg::fast_half_div - 1)
                           : sd_pkg::div_w'(sd_pkg::slow_half_div - 1);
  assign toggle = (cnt == half_div);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
      sd_sclk <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      fast_q <= 1'b0;
    end else if (!run) begin
      // parked low, restarts with a full half period
      cnt <= '0;
      sd_sclk <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      if (toggle) begin
        cnt <= '0;
        sd_sclk <= ~sd_sclk;
        // strobes line up with the new sclk level
        sclk_rise <= ~sd_sclk;
        sclk_fall <= sd_sclk;
        fast_q <= fast_sel;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== sd_init/sd_cmd_shifter.sv ====
`timescale 1ns/10ps

module sd_cmd_shifter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  sd_pkg::sd_cmd_req_t        req,
  input  logic                       sclk_rise,
  input  logic                       sclk_fall,
  input  logic                       sd_miso,
  output logic                       sd_mosi,
  output logic                       busy,
  output logic                       cmd_done,
  output logic [sd_pkg::r7_bits-1:0] resp,
  output logic                       timed_out
);

  typedef enum logic [1:0] {
    sh_idle,
    sh_send,
    sh_hunt,
    sh_collect
  } shift_state_t;

  shift_state_t state;
  // msb leaves first
  logic [sd_pkg::cmd_bits-1:0] frame;
  logic [6:0] crc;
  logic [6:0] crc_next;
  logic crc_fb;
  // frame bit, then response bit counter
  logic [5:0] bit_cnt;
  logic [5:0] resp_len;
  logic [6:0] tmo_cnt;

  // crc7, x^7 + x^3 + 1, fed with the bit going out
  assign crc_fb = frame[sd_pkg::cmd_bits-1] ^ crc[6];
  assign crc_next = {crc[5:3], crc[2] ^ crc_fb, crc[1:0], crc_fb};

  assign busy = (state != sh_idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sh_idle;
      sd_mosi <= 1'b1;
      cmd_done <= 1'b0;
      timed_out <= 1'b0;
      resp <= '1;
      bit_cnt <= '0;
      tmo_cnt <= '0;
    end else begin
      cmd_done <= 1'b0;
      case (state)
        sh_idle: begin
          if (start) begin
            // start bits 01, index, argument, crc slot and end bit as ones for now
            frame <= {2'b01, req.index, req.argument, 8'hff};
            crc <= '0;
            resp_len <= req.resp_len;
            bit_cnt <= '0;
            tmo_cnt <= '0;
            resp <= '1;
            timed_out <= 1'b0;
            state <= sh_send;
          end
        end
        sh_send: begin
          if (sclk_fall) begin
            sd_mosi <= frame[sd_pkg::cmd_bits-1];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == sd_pkg::cmd_bits - 9) begin
              // last argument bit goes now, crc and end bit follow
              crc <= crc_next;
              frame <= {crc_next, 1'b1, {(sd_pkg::cmd_bits - 8){1'b1}}};
            end else begin
              if (bit_cnt < sd_pkg::cmd_bits - 8) begin
                crc <= crc_next;
              end
              frame <= {frame[sd_pkg::cmd_bits-2:0], 1'b1};
            end
            // end bit is out, mosi stays high from here
            if (bit_cnt == sd_pkg::cmd_bits - 1) begin
              state <= sh_hunt;
            end
          end
        end
        sh_hunt: begin
          if (sclk_rise) begin
            if (!sd_miso) begin
              // start bit of r1 is its msb, always 0
              resp[sd_pkg::r7_bits-1] <= 1'b0;
              bit_cnt <= 6'd1;
              state <= sh_collect;
            end else if (tmo_cnt == sd_pkg::resp_timeout_sclk - 1) begin
              // no answer, resp stays all ones
              timed_out <= 1'b1;
              cmd_done <= 1'b1;
              state <= sh_idle;
            end else begin
              tmo_cnt <= tmo_cnt + 1'b1;
            end
          end
        end
        sh_collect: begin
          if (sclk_rise) begin
            // left aligned, so short responses keep ones below
            resp[sd_pkg::r7_bits - 1 - bit_cnt] <= sd_miso;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == resp_len - 1'b1) begin
              cmd_done <= 1'b1;
              state <= sh_idle;
            end
          end
        end
        default: state <= sh_idle;
      endcase
    end
  end

endmodule

// ==== sd_init/sd_init_seq.sv ====
`timescale 1ns/10ps

module sd_init_seq (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cmd_done,
  input  logic [sd_pkg::r7_bits-1:0] resp,
  input  logic                       timed_out,
  input  logic                       push_ready,
  output logic                       start,
  output sd_pkg::sd_cmd_req_t        req,
  output logic                       sclk_run,
  output logic                       fast_sel,
  output logic                       sd_cs,
  output logic                       push_valid,
  output sd_pkg::resp_rec_t          push_rec,
  output logic                       init_done,
  output logic                       init_error,
  output logic                       high_capacity
);

  sd_pkg::init_state_t state;
  sd_pkg::init_state_t next_state;
  logic [5:0] cur_cmd;
  logic [5:0] next_cmd;
  logic [sd_pkg::pwr_cnt_w-1:0] pwr_cnt;
  logic [3:0] retry_cnt;
  // first cmd58 done, the next one reads ccs
  logic ocr_seen;
  logic [7:0] r1;
  logic echo_ok;

  assign r1 = resp[sd_pkg::r7_bits-1 -: sd_pkg::r1_bits];
  // cmd8 echo, voltage accepted 1 and pattern 0xaa
  assign echo_ok = (resp[11:8] == 4'h1) && (resp[7:0] == 8'haa);
  assign push_valid = (state == sd_pkg::st_push);

  // argument and response length per command
  always_comb begin
    req.index = cur_cmd;
    req.argument = '0;
    req.resp_len = 6'(sd_pkg::r1_bits);
    case (cur_cmd)
      sd_pkg::cmd8: begin
        req.argument = sd_pkg::cmd8_arg;
        req.resp_len = 6'(sd_pkg::r7_bits);
      end
      sd_pkg::cmd58: req.resp_len = 6'(sd_pkg::r7_bits);
      sd_pkg::acmd41: req.argument = sd_pkg::acmd41_arg;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sd_pkg::st_powerup;
      next_state <= sd_pkg::st_powerup;
      cur_cmd <= sd_pkg::cmd0;
      next_cmd <= sd_pkg::cmd0;
      pwr_cnt <= '0;
      retry_cnt <= '0;
      ocr_seen <= 1'b0;
      start <= 1'b0;
      sclk_run <= 1'b0;
      fast_sel <= 1'b0;
      sd_cs <= 1'b1;
      init_done <= 1'b0;
      init_error <= 1'b0;
      high_capacity <= 1'b0;
    end else begin
      start <= 1'b0;
      // clock parks once the card is given up
      sclk_run <= (state != sd_pkg::st_error);
      case (state)
        sd_pkg::st_powerup: begin
          // counts along with the slow clock, shifter idles with mosi high
          if (sclk_run) begin
            pwr_cnt <= pwr_cnt + 1'b1;
            if (pwr_cnt == sd_pkg::powerup_cycles - 1) begin
              sd_cs <= 1'b0;
              state <= sd_pkg::st_issue;
            end
          end
        end
        sd_pkg::st_issue: begin
          start <= 1'b1;
          state <= sd_pkg::st_wait;
        end
        sd_pkg::st_wait: begin
          if (cmd_done) begin
            push_rec.cmd_index <= cur_cmd;
            push_rec.r1 <= r1;
            push_rec.timed_out <= timed_out;
            next_state <= sd_pkg::st_issue;
            state <= sd_pkg::st_push;
            case (cur_cmd)
              sd_pkg::cmd0: begin
                if (r1 == 8'h01) begin
                  next_cmd <= sd_pkg::cmd8;
                  retry_cnt <= '0;
                end else if (retry_cnt == sd_pkg::retry_limit - 1) begin
                  next_state <= sd_pkg::st_error;
                end else begin
                  retry_cnt <= retry_cnt + 1'b1;
                end
              end
              sd_pkg::cmd8: begin
                // 0x05 is an older card without cmd8
                next_cmd <= sd_pkg::cmd58;
                if (!(r1 == 8'h05 || (r1 == 8'h01 && echo_ok))) begin
                  next_state <= sd_pkg::st_error;
                end
              end
              sd_pkg::cmd58: begin
                if (!ocr_seen) begin
                  ocr_seen <= 1'b1;
                  next_cmd <= sd_pkg::cmd55;
                end else begin
                  // ocr bit 30, ccs
                  high_capacity <= resp[30];
                  next_state <= sd_pkg::st_done;
                end
              end
              sd_pkg::cmd55: next_cmd <= sd_pkg::acmd41;
              sd_pkg::acmd41: begin
                if (r1 == 8'h01) begin
                  // still idle, another cmd55/acmd41 pair
                  next_cmd <= sd_pkg::cmd55;
                  retry_cnt <= retry_cnt + 1'b1;
                  if (retry_cnt == sd_pkg::retry_limit - 1) begin
                    next_state <= sd_pkg::st_error;
                  end
                end else if (r1 == 8'h00) begin
                  next_cmd <= sd_pkg::cmd58;
                end else begin
                  next_state <= sd_pkg::st_error;
                end
              end
              default: next_state <= sd_pkg::st_error;
            endcase
          end
        end
        sd_pkg::st_push: begin
          // record leaves before anything else happens
          if (push_ready) begin
            state <= next_state;
            cur_cmd <= next_cmd;
            if (next_state == sd_pkg::st_done) begin
              fast_sel <= 1'b1;
              init_done <= 1'b1;
            end
            if (next_state == sd_pkg::st_error) begin
              init_error <= 1'b1;
            end
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// ==== sd_init/sd_init_top.sv ====
`timescale 1ns/10ps

module sd_init_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              sd_miso,
  input  logic              log_ready,
  output logic              sd_sclk,
  output logic              sd_mosi,
  output logic              sd_cs,
  output logic              init_done,
  output logic              init_error,
  output logic              high_capacity,
  output logic              log_valid,
  output sd_pkg::resp_rec_t log_rec
);

  logic sclk_run;
  logic fast_sel;
  logic sclk_rise;
  logic sclk_fall;
  logic cmd_start;
  sd_pkg::sd_cmd_req_t cmd_req;
  logic cmd_busy;
  logic cmd_done;
  logic [sd_pkg::r7_bits-1:0] cmd_resp;
  logic cmd_timed_out;
  logic push_valid;
  logic push_ready;
  sd_pkg::resp_rec_t push_rec;

  sd_clock_gen clock_gen (
    .clk(clk), .reset(reset), .run(sclk_run), .fast_sel(fast_sel),
    .sd_sclk(sd_sclk), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall)
  );

  // cmd_busy is observed by the bound checker
  sd_cmd_shifter cmd_shifter (
    .clk(clk), .reset(reset), .start(cmd_start), .req(cmd_req),
    .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .sd_miso(sd_miso),
    .sd_mosi(sd_mosi), .busy(cmd_busy), .cmd_done(cmd_done),
    .resp(cmd_resp), .timed_out(cmd_timed_out)
  );

  sd_init_seq init_seq (
    .clk(clk), .reset(reset), .cmd_done(cmd_done), .resp(cmd_resp),
    .timed_out(cmd_timed_out), .push_ready(push_ready), .start(cmd_start),
    .req(cmd_req), .sclk_run(sclk_run), .fast_sel(fast_sel), .sd_cs(sd_cs),
    .push_valid(push_valid), .push_rec(push_rec), .init_done(init_done),
    .init_error(init_error), .high_capacity(high_capacity)
  );

  resp_log_fifo log_fifo (
    .clk(clk), .reset(reset), .in_valid(push_valid), .in_rec(push_rec),
    .out_ready(log_ready), .in_ready(push_ready), .out_valid(log_valid),
    .out_rec(log_rec)
  );

endmodule

// ==== tests/sd_card_model.sv ====
`timescale 1ns/10ps

module sd_card_model (
  input  logic       reset,
  input  logic       sd_sclk,
  input  logic       sd_cs,
  input  logic       sd_mosi,
  output logic       sd_miso,
  // card behavior for the current test
  input  logic [3:0] cmd0_fails,
  // 1: failed cmd0 gets no answer, 0: it gets r1 0x00
  input  logic       cmd0_silent,
  // 0 echo, 1 illegal command, 2 wrong check pattern
  input  logic [1:0] cmd8_mode,
  input  logic [3:0] acmd41_idle,
  input  logic       ccs,
  output int         bad_frames
);

  logic [47:0] frame;
  logic [39:0] answer;
  // bits of answer to send, 0 means no answer
  int answer_len;
  int cmd0_seen;
  int acmd41_seen;
  // left idle state after acmd41
  logic card_ready;
  int bit_i;

  // crc7 over index and argument, x^7 + x^3 + 1
  function automatic logic [6:0] crc7(input logic [39:0] bits);
    logic [6:0] c;
    logic fb;
    int i;
    c = '0;
    for (i = 39; i >= 0; i--) begin
      fb = bits[i] ^ c[6];
      c = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return c;
  endfunction

  // answer for the frame just taken in
  task automatic decide;
    logic [5:0] idx;
    logic [31:0] arg;
    idx = frame[45:40];
    arg = frame[39:8];
    answer = '1;
    answer_len = 8;
    case (idx)
      6'd0: begin
        if (cmd0_seen < int'(cmd0_fails)) begin
          cmd0_seen++;
          if (cmd0_silent) begin
            answer_len = 0;
          end else begin
            answer[39:32] = 8'h00;
          end
        end else begin
          // software reset, back to idle
          card_ready = 1'b0;
          acmd41_seen = 0;
          answer[39:32] = 8'h01;
        end
      end
      6'd8: begin
        if (cmd8_mode == 2'd1) begin
          // older card, r1 only
          answer[39:32] = 8'h05;
        end else begin
          answer_len = 40;
          answer = {8'h01, 20'h0, arg[11:8], (cmd8_mode == 2'd2) ? 8'h55 : arg[7:0]};
        end
      end
      6'd55: answer[39:32] = card_ready ? 8'h00 : 8'h01;
      6'd41: begin
        if (acmd41_seen < int'(acmd41_idle)) begin
          acmd41_seen++;
          answer[39:32] = 8'h01;
        end else begin
          card_ready = 1'b1;
          answer[39:32] = 8'h00;
        end
      end
      6'd58: begin
        // ocr, power-up status bit 31 and ccs bit 30 once ready
        answer_len = 40;
        answer = {card_ready ? 8'h00 : 8'h01, card_ready, card_ready & ccs, 30'h00ff_8000};
      end
      default: answer[39:32] = 8'h04;
    endcase
  endtask

  initial begin
    sd_miso = 1'b1;
    bad_frames = 0;
    cmd0_seen = 0;
    acmd41_seen = 0;
    card_ready = 1'b0;
    forever begin
      @(posedge sd_sclk or posedge reset);
      if (reset) begin
        sd_miso = 1'b1;
        bad_frames = 0;
        cmd0_seen = 0;
        acmd41_seen = 0;
        card_ready = 1'b0;
      end else if (!sd_cs && !sd_mosi) begin
        // start bit seen, mosi sampled on rising edges
        frame[47] = 1'b0;
        for (bit_i = 46; bit_i >= 0; bit_i--) begin
          @(posedge sd_sclk);
          frame[bit_i] = sd_mosi;
        end
        if (frame[46] != 1'b1 || frame[0] != 1'b1 || crc7(frame[47:8]) != frame[7:1]) begin
          bad_frames++;
        end else begin
          decide();
          if (answer_len != 0) begin
            // 8 idle bits, then the answer msb first on falling edges
            repeat (8) @(negedge sd_sclk);
            for (bit_i = 0; bit_i < answer_len; bit_i++) begin
              @(negedge sd_sclk);
              sd_miso = answer[39 - bit_i];
            end
            @(negedge sd_sclk);
            sd_miso = 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== tests/sd_init_chk.sv ====
`timescale 1ns/10ps

module sd_init_check (
  input logic              clk,
  input logic              reset,
  input logic              sclk_rise,
  input logic              sclk_fall,
  input logic              sd_cs,
  input logic              sd_mosi,
  input logic              cmd_start,
  input logic              cmd_busy,
  input logic              log_valid,
  input logic              log_ready,
  input sd_pkg::resp_rec_t log_rec,
  input logic              init_done,
  input logic              init_error
);

  // slow rising edges counted since reset up to the power-up count
  logic [6:0] rise_cnt;
  // assertion failures so far, read by the testbench
  int failures = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      rise_cnt <= '0;
    end else if (sclk_rise && rise_cnt != 7'(sd_pkg::powerup_sclk)) begin
      rise_cnt <= rise_cnt + 1'b1;
    end
  end

  // cs high through the whole power-up clocking
  cs_powerup: assert property (@(posedge clk) disable iff (reset)
    (rise_cnt < 7'(sd_pkg::powerup_sclk)) |-> sd_cs)
    else begin
      $error("cs low before the power-up clocks were sent");
      failures++;
    end

  // stalled record holds still
  rec_hold: assert property (@(posedge clk) disable iff (reset)
    (log_valid && !log_ready) |=> (log_valid && $stable(log_rec)))
    else begin
      $error("log record changed or dropped while stalled");
      failures++;
    end

  result_excl: assert property (@(posedge clk) disable iff (reset)
    !(init_done && init_error))
    else begin
      $error("init_done and init_error high together");
      failures++;
    end

  // mosi moves one cycle after the falling strobe in mode 0
  mosi_edge: assert property (@(posedge clk) disable iff (reset)
    $changed(sd_mosi) |-> $past(sclk_fall))
    else begin
      $error("mosi changed away from a falling sclk edge");
      failures++;
    end

  // next command only once the shifter is back to idle
  start_idle: assert property (@(posedge clk) disable iff (reset)
    cmd_start |-> !cmd_busy)
    else begin
      $error("command started while the shifter was still busy");
      failures++;
    end

endmodule

// ==== tests/tb_sd_init.sv ====
`timescale 1ns/10ps

module tb_sd_init;

  // card behavior and expected result of one test
  typedef struct packed {
    logic [3:0] cmd0_fails;
    logic       cmd0_silent;
    logic [1:0] cmd8_mode;
    logic [3:0] acmd41_idle;
    logic       ccs;
    logic       random_ready;
    logic       exp_error;
    logic       exp_hc;
  } row_t;

  localparam int n_rows = 8;
  localparam int clk_ns = 100;
  // worst case with every cmd0 retry and acmd41 round plus cmd8 and both cmd58
  localparam int max_cmds = 3 * sd_pkg::retry_limit + 3;
  // sclk per command as frame plus timeout or gap plus long answer
  localparam int cmd_sclk = sd_pkg::cmd_bits + sd_pkg::resp_timeout_sclk + sd_pkg::r7_bits + 8;
  localparam longint row_ns = longint'(sd_pkg::powerup_sclk + max_cmds * cmd_sclk + 100)
    * 2 * sd_pkg::slow_half_div * clk_ns;
  localparam longint watchdog_ns = n_rows * row_ns;

  string names [n_rows] = '{"v2_high_capacity", "silent_card", "v1_cmd8_illegal",
    "bad_cmd8_echo", "acmd41_three_idle", "acmd41_never_ready", "cmd0_nonidle_retry",
    "backpressure"};
  // cmd8 mode 0 echo, 1 illegal, 2 bad pattern
  row_t rows [n_rows] = '{
    '{4'd0, 1'b1, 2'd0, 4'd0, 1'b1, 1'b0, 1'b0, 1'b1},
    '{4'd15, 1'b1, 2'd0, 4'd0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{4'd0, 1'b1, 2'd1, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{4'd0, 1'b1, 2'd2, 4'd0, 1'b1, 1'b0, 1'b1, 1'b0},
    '{4'd0, 1'b1, 2'd0, 4'd3, 1'b1, 1'b0, 1'b0, 1'b1},
    '{4'd0, 1'b1, 2'd0, 4'd10, 1'b1, 1'b0, 1'b1, 1'b0},
    '{4'd2, 1'b0, 2'd0, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0},
    '{4'd0, 1'b1, 2'd0, 4'd0, 1'b1, 1'b1, 1'b0, 1'b1}
  };

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic log_ready = 1'b1;
  logic sd_miso;
  logic sd_sclk;
  logic sd_mosi;
  logic sd_cs;
  logic init_done;
  logic init_error;
  logic high_capacity;
  logic log_valid;
  sd_pkg::resp_rec_t log_rec;
  int bad_frames;
  row_t cfg = '0;
  integer seed = 32'h5bbe_8445;
  integer rnd;
  sd_pkg::resp_rec_t exp_q [$];
  sd_pkg::resp_rec_t got_q [$];
  int errors = 0;
  int checks = 0;

  always #50 clk = ~clk;

  sd_init_top UUT (
    .clk(clk), .reset(reset), .sd_miso(sd_miso), .log_ready(log_ready),
    .sd_sclk(sd_sclk), .sd_mosi(sd_mosi), .sd_cs(sd_cs), .init_done(init_done),
    .init_error(init_error), .high_capacity(high_capacity), .log_valid(log_valid),
    .log_rec(log_rec)
  );

  sd_card_model card (
    .reset(reset), .sd_sclk(sd_sclk), .sd_cs(sd_cs), .sd_mosi(sd_mosi), .sd_miso(sd_miso),
    .cmd0_fails(cfg.cmd0_fails), .cmd0_silent(cfg.cmd0_silent), .cmd8_mode(cfg.cmd8_mode),
    .acmd41_idle(cfg.acmd41_idle), .ccs(cfg.ccs), .bad_frames(bad_frames)
  );

  bind sd_init_top sd_init_check chk (
    .clk(clk), .reset(reset), .sclk_rise(sclk_rise), .sclk_fall(sclk_fall), .sd_cs(sd_cs),
    .sd_mosi(sd_mosi), .cmd_start(cmd_start), .cmd_busy(cmd_busy),
    .log_valid(log_valid), .log_ready(log_ready), .log_rec(log_rec),
    .init_done(init_done), .init_error(init_error)
  );

  // log stream consumer that stalls at random on some rows
  always @(posedge clk) begin
    rnd = $random(seed);
    log_ready <= cfg.random_ready ? rnd[0] : 1'b1;
  end

  always @(posedge clk) begin
    if (reset) begin
      got_q.delete();
    end else if (log_valid && log_ready) begin
      got_q.push_back(log_rec);
    end
  end

  function automatic sd_pkg::resp_rec_t make_rec(input logic [5:0] idx, input logic [7:0] r1,
                                                 input logic to);
    return {idx, r1, to};
  endfunction

  // records the init rules predict for one card
  task automatic build_expected(input row_t r);
    int n;
    exp_q.delete();
    for (n = 0; n < sd_pkg::retry_limit && n < int'(r.cmd0_fails); n++) begin
      if (r.cmd0_silent) begin
        exp_q.push_back(make_rec(sd_pkg::cmd0, 8'hff, 1'b1));
      end else begin
        exp_q.push_back(make_rec(sd_pkg::cmd0, 8'h00, 1'b0));
      end
    end
    if (int'(r.cmd0_fails) >= sd_pkg::retry_limit) return;
    exp_q.push_back(make_rec(sd_pkg::cmd0, 8'h01, 1'b0));
    exp_q.push_back(make_rec(sd_pkg::cmd8, (r.cmd8_mode == 2'd1) ? 8'h05 : 8'h01, 1'b0));
    if (r.cmd8_mode == 2'd2) return;
    exp_q.push_back(make_rec(sd_pkg::cmd58, 8'h01, 1'b0));
    for (n = 0; n < sd_pkg::retry_limit && n < int'(r.acmd41_idle); n++) begin
      exp_q.push_back(make_rec(sd_pkg::cmd55, 8'h01, 1'b0));
      exp_q.push_back(make_rec(sd_pkg::acmd41, 8'h01, 1'b0));
    end
    if (int'(r.acmd41_idle) >= sd_pkg::retry_limit) return;
    exp_q.push_back(make_rec(sd_pkg::cmd55, 8'h01, 1'b0));
    exp_q.push_back(make_rec(sd_pkg::acmd41, 8'h00, 1'b0));
    exp_q.push_back(make_rec(sd_pkg::cmd58, 8'h00, 1'b0));
  endtask

  task automatic check_val(input string test, input string what, input logic [39:0] exp,
                           input logic [39:0] act);
    checks++;
    assert (exp == act) else begin
      $display("MISMATCH %s %s: expected %0h actual %0h", test, what, exp, act);
      errors++;
    end
  endtask

  // one high phase of sd_sclk in system cycles
  task automatic measure_half(output int cycles);
    cycles = 0;
    while (sd_sclk) @(posedge clk);
    while (!sd_sclk) @(posedge clk);
    while (sd_sclk) begin
      cycles++;
      @(posedge clk);
    end
  endtask

  initial begin
    int t;
    int i;
    int n;
    int half;
    int test_err;
    int chk_failures;
    chk_failures = 0;
    for (t = 0; t < n_rows; t++) begin
      @(posedge clk);
      reset <= 1'b1;
      cfg <= rows[t];
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      build_expected(rows[t]);
      test_err = errors;
      while (!(init_done || init_error)) @(posedge clk);
      // let the fifo empty
      do @(posedge clk); while (log_valid);
      @(posedge clk);
      check_val(names[t], "init_error", 40'(rows[t].exp_error), 40'(init_error));
      check_val(names[t], "init_done", 40'(!rows[t].exp_error), 40'(init_done));
      check_val(names[t], "high_capacity", 40'(rows[t].exp_hc), 40'(high_capacity));
      check_val(names[t], "record count", 40'(exp_q.size()), 40'(got_q.size()));
      n = (exp_q.size() < got_q.size()) ? exp_q.size() : got_q.size();
      for (i = 0; i < n; i++) begin
        check_val(names[t], $sformatf("record %0d", i), 40'(exp_q[i]), 40'(got_q[i]));
      end
      checks++;
      assert (bad_frames == 0) else begin
        $display("%s: card rejected %0d command frames for bad crc7 or framing",
                 names[t], bad_frames);
        errors++;
      end
      if (!rows[t].exp_error) begin
        measure_half(half);
        check_val(names[t], "fast half period", 40'(sd_pkg::fast_half_div), 40'(half));
      end
      checks++;
      if (UUT.chk.failures != chk_failures) begin
        $display("%s: bound checker assertions failed %0d times", names[t],
                 UUT.chk.failures - chk_failures);
        errors += UUT.chk.failures - chk_failures;
        chk_failures = UUT.chk.failures;
      end
      $display("%s: %0d records, %s", names[t], got_q.size(),
               (errors == test_err) ? "ok" : "failed");
    end
    $display("summary: %0d tests, %0d checks, %0d errors", n_rows, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: tests did not finish within %0d ns", watchdog_ns);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== build.f ====
common/sd_pkg.sv
logic/resp_log_fifo.sv
sd_init/sd_clock_gen.sv
sd_init/sd_cmd_shifter.sv
sd_init/sd_init_seq.sv
sd_init/sd_init_top.sv
tests/sd_card_model.sv
tests/sd_init_chk.sv
tests/tb_sd_init.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sd_init
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
